// File: verilog/video_pkg.sv
// video generator definitions: mode constants, register map and shared types
`default_nettype none

package video_pkg;

    // tiny mode, 48 x 12 total with 32 x 8 visible
    localparam int H_TOTAL          = 48;   // pixel clocks per line
    localparam int H_OFFSCREEN      = 16;   // blank pixels before visible
    localparam int H_SYNC_START     = 4;
    localparam int H_SYNC_END       = 10;   // hsync high for h_count in [start, end)
    localparam int VISIBLE_WIDTH    = 32;
    localparam int VISIBLE_HEIGHT   = 8;
    localparam int V_TOTAL          = 12;   // lines per frame
    localparam int V_SYNC_START     = 9;
    localparam int V_SYNC_END       = 10;

    // line fetch
    localparam int FETCH_LEAD       = 8;    // clocks ahead of first visible pixel
    localparam int FETCH_CREDITS    = 2;    // shifter word buffer depth

    // counter widths
    localparam int H_W              = 6;
    localparam int V_W              = 4;

    typedef logic [15:0]    word_t;
    typedef logic [15:0]    addr_t;         // vram word address
    typedef logic [7:0]     color_t;        // palette index
    typedef logic [H_W-1:0] hres_t;
    typedef logic [V_W-1:0] vres_t;
    typedef logic [3:0]     reg_num_t;

    localparam color_t DEFAULT_BORDER   = 8'h08;
    localparam int DEFAULT_LINE_LEN     = VISIBLE_WIDTH / 2;   // two pixels per word

    // register map
    localparam reg_num_t XR_VID_CTRL    = 4'h0;
    localparam reg_num_t XR_VID_INTR    = 4'h1;     // write only
    localparam reg_num_t XR_VID_LEFT    = 4'h2;
    localparam reg_num_t XR_VID_RIGHT   = 4'h3;
    localparam reg_num_t XR_SCANLINE    = 4'h4;     // read only
    localparam reg_num_t XR_VID_HSIZE   = 4'h5;     // read only
    localparam reg_num_t XR_VID_VSIZE   = 4'h6;     // read only
    localparam reg_num_t XR_PA_GFX_CTRL = 4'h8;
    localparam reg_num_t XR_PA_DISP_ADDR = 4'h9;
    localparam reg_num_t XR_PA_LINE_LEN = 4'hA;

    // playfield graphics control word
    typedef struct packed {
        color_t     colorbase;      // xor'd into every pixel index
        logic       blank;
        logic [6:0] reserved;
    } gfx_ctrl_t;

    // register write word, raw value or gfx control fields
    typedef union packed {
        word_t      raw;
        gfx_ctrl_t  gfx;
    } reg_word_u;

    typedef struct packed {
        color_t     border;
        hres_t      left;           // first window pixel
        hres_t      right;          // one past last window pixel
        color_t     colorbase;
        logic       blank;
        addr_t      start_addr;
        word_t      line_len;       // words per line
    } vid_cfg_t;

    typedef struct packed {
        hres_t      h_count;
        vres_t      v_count;
        logic       h_visible;
        logic       v_visible;
        logic       hsync;
        logic       vsync;
        logic       fetch_start;    // one clock, visible unblanked lines only
        logic       end_of_line;
        logic       end_of_frame;
        logic       end_of_visible;
    } raster_t;

    typedef struct packed {
        logic       valid;
        word_t      data;
    } fetch_word_t;

endpackage

`default_nettype wire

// File: verilog/video_timing.sv
// raster timing generator: line and frame counters, sync, visibility and line strobes
`default_nettype none

module video_timing (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               cfg_blank_i,    // playfield blanked, no fetch
    output video_pkg::raster_t      raster_o
);

    video_pkg::hres_t   h_count;
    video_pkg::vres_t   v_count;
    video_pkg::hres_t   h_next;
    video_pkg::vres_t   v_next;
    logic               hsync;
    logic               vsync;
    logic               end_of_line;
    logic               last_line;
    logic               v_visible;

    // next counter values
    always_comb begin
        end_of_line = (h_count == $bits(h_count)'(video_pkg::H_TOTAL - 1));
        last_line   = (v_count == $bits(v_count)'(video_pkg::V_TOTAL - 1));
        h_next      = end_of_line ? '0 : h_count + $bits(h_count)'(1);
        v_next      = v_count;
        if (end_of_line) begin
            v_next  = last_line ? '0 : v_count + $bits(v_count)'(1);
        end
    end

    // sync registered from next count so it lines up with the counters
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
        end else begin
            h_count <= h_next;
            v_count <= v_next;
            hsync   <= (h_next >= $bits(h_next)'(video_pkg::H_SYNC_START)) &&
                       (h_next <  $bits(h_next)'(video_pkg::H_SYNC_END));
            vsync   <= (v_next >= $bits(v_next)'(video_pkg::V_SYNC_START)) &&
                       (v_next <  $bits(v_next)'(video_pkg::V_SYNC_END));
        end
    end

    assign v_visible = (v_count < $bits(v_count)'(video_pkg::VISIBLE_HEIGHT));

    always_comb begin
        raster_o.h_count        = h_count;
        raster_o.v_count        = v_count;
        raster_o.h_visible      = (h_count >= $bits(h_count)'(video_pkg::H_OFFSCREEN));
        raster_o.v_visible      = v_visible;
        raster_o.hsync          = hsync;
        raster_o.vsync          = vsync;
        raster_o.fetch_start    = v_visible && !cfg_blank_i &&
            (h_count == $bits(h_count)'(video_pkg::H_OFFSCREEN - video_pkg::FETCH_LEAD));
        raster_o.end_of_line    = end_of_line;
        raster_o.end_of_frame   = end_of_line && last_line;
        raster_o.end_of_visible = end_of_line &&
            (v_count == $bits(v_count)'(video_pkg::VISIBLE_HEIGHT - 1));
    end

endmodule

`default_nettype wire

// File: verilog/video_regs.sv
// video register file: write decode, registered readback and video interrupt
`default_nettype none

module video_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   reg_wr_i,       // register write strobe
    input  wire video_pkg::reg_num_t    reg_num_i,
    input  wire video_pkg::reg_word_u   reg_data_i,
    input  wire video_pkg::raster_t     raster_i,
    output video_pkg::word_t            reg_data_o,     // one clock after reg_num_i
    output logic                        video_intr_o,
    output video_pkg::vid_cfg_t         cfg_o
);

    video_pkg::gfx_ctrl_t   gfx_rd;         // gfx control readback view
    video_pkg::word_t       rd_word;
    logic                   intr_wr;

    assign intr_wr = reg_wr_i && (reg_num_i == video_pkg::XR_VID_INTR);

    // register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_o.border        <= video_pkg::DEFAULT_BORDER;
            cfg_o.left          <= '0;
            cfg_o.right         <= $bits(cfg_o.right)'(video_pkg::VISIBLE_WIDTH);
            cfg_o.colorbase     <= '0;
            cfg_o.blank         <= 1'b1;        // playfield starts blanked
            cfg_o.start_addr    <= '0;
            cfg_o.line_len      <= $bits(cfg_o.line_len)'(video_pkg::DEFAULT_LINE_LEN);
        end else if (reg_wr_i) begin
            case (reg_num_i)
                video_pkg::XR_VID_CTRL: begin
                    cfg_o.border        <= reg_data_i.raw[7:0];
                end
                video_pkg::XR_VID_LEFT: begin
                    cfg_o.left          <= reg_data_i.raw[video_pkg::H_W-1:0];
                end
                video_pkg::XR_VID_RIGHT: begin
                    cfg_o.right         <= reg_data_i.raw[video_pkg::H_W-1:0];
                end
                video_pkg::XR_PA_GFX_CTRL: begin
                    cfg_o.colorbase     <= reg_data_i.gfx.colorbase;
                    cfg_o.blank         <= reg_data_i.gfx.blank;
                end
                video_pkg::XR_PA_DISP_ADDR: begin
                    cfg_o.start_addr    <= reg_data_i.raw;  // takes effect next frame
                end
                video_pkg::XR_PA_LINE_LEN: begin
                    cfg_o.line_len      <= reg_data_i.raw;
                end
                default: begin
                end
            endcase
        end
    end

    // one clock pulse at end of visible area or on software trigger
    always_ff @(posedge clk) begin
        if (reset_i) begin
            video_intr_o <= 1'b0;
        end else begin
            video_intr_o <= raster_i.end_of_visible || intr_wr;
        end
    end

    // readback mux
    always_comb begin
        gfx_rd.colorbase    = cfg_o.colorbase;
        gfx_rd.blank        = cfg_o.blank;
        gfx_rd.reserved     = '0;       // reads as zero

        case (reg_num_i)
            video_pkg::XR_VID_CTRL:     rd_word = {8'h00, cfg_o.border};
            video_pkg::XR_VID_LEFT:     rd_word = 16'(cfg_o.left);
            video_pkg::XR_VID_RIGHT:    rd_word = 16'(cfg_o.right);
            video_pkg::XR_SCANLINE:     rd_word = 16'(raster_i.v_count);   // live line
            video_pkg::XR_VID_HSIZE:    rd_word = 16'(video_pkg::VISIBLE_WIDTH);
            video_pkg::XR_VID_VSIZE:    rd_word = 16'(video_pkg::VISIBLE_HEIGHT);
            video_pkg::XR_PA_GFX_CTRL:  rd_word = gfx_rd;
            video_pkg::XR_PA_DISP_ADDR: rd_word = cfg_o.start_addr;
            video_pkg::XR_PA_LINE_LEN:  rd_word = cfg_o.line_len;
            default:                    rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_word;
    end

endmodule

`default_nettype wire

// File: verilog/line_fetch.sv
// playfield line fetcher: per-line vram addressing with credit-limited reads
`default_nettype none

module line_fetch (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire video_pkg::raster_t     raster_i,
    input  wire video_pkg::vid_cfg_t    cfg_i,
    input  wire logic                   credit_i,       // one word consumed by shifter
    output logic                        vram_sel_o,
    output video_pkg::addr_t            vram_addr_o,
    input  wire video_pkg::word_t       vram_data_i,
    output video_pkg::fetch_word_t      word_o
);

    video_pkg::addr_t   line_base;      // first word of current line
    video_pkg::addr_t   word_ptr;       // next word to read
    logic [1:0]         credits;        // free shifter buffer slots
    logic               rd_pending;     // read issued last clock

    // a read every clock while the shifter has room
    assign vram_sel_o   = (credits != 2'd0);
    assign vram_addr_o  = word_ptr;

    // line base, reloaded each frame and stepped each line
    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_base <= '0;
        end else if (raster_i.end_of_frame) begin
            line_base <= cfg_i.start_addr;
        end else if (raster_i.end_of_line) begin
            line_base <= line_base + cfg_i.line_len;
        end
    end

    always_ff @(posedge clk) begin
        if (raster_i.fetch_start) begin
            word_ptr <= line_base;
        end else if (vram_sel_o) begin
            word_ptr <= word_ptr + $bits(word_ptr)'(1);
        end
    end

    // credit count, refilled at line start
    always_ff @(posedge clk) begin
        if (reset_i) begin
            credits     <= '0;
            rd_pending  <= 1'b0;
        end else begin
            rd_pending  <= vram_sel_o;
            if (raster_i.fetch_start) begin
                credits <= $bits(credits)'(video_pkg::FETCH_CREDITS);
            end else begin
                credits <= credits - $bits(credits)'(vram_sel_o)
                                   + $bits(credits)'(credit_i);
            end
        end
    end

    // fixed one clock vram latency, data goes straight on
    always_comb begin
        word_o.valid    = rd_pending;
        word_o.data     = vram_data_i;
    end

endmodule

`default_nettype wire

// File: verilog/pixel_shifter.sv
// playfield pixel shifter: word buffer, byte select, colourbase xor, border and output regs
`default_nettype none

module pixel_shifter (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire video_pkg::raster_t     raster_i,
    input  wire video_pkg::vid_cfg_t    cfg_i,
    input  wire video_pkg::fetch_word_t word_i,
    output logic                        credit_o,       // pulse per word popped
    output video_pkg::color_t           color_index_o,
    output logic                        dv_de_o,
    output logic                        hsync_o,
    output logic                        vsync_o
);

    typedef struct packed {
        logic   de;
        logic   hsync;
        logic   vsync;
        logic   win;        // inside active window, not blanked
        logic   odd;        // low byte of word
    } pix_pos_t;

    typedef struct packed {
        logic               de;
        logic               hsync;
        logic               vsync;
        logic               win;
        video_pkg::color_t  pix;
    } pix_data_t;

    video_pkg::word_t   buf_mem [2];
    logic               wr_ptr;
    logic               rd_ptr;
    logic [1:0]         count;
    video_pkg::hres_t   x_pos;
    video_pkg::word_t   head;
    logic               visible;
    logic               pop;
    pix_pos_t           s0;
    pix_pos_t           s1;
    pix_data_t          s2;

    // pixel position from raster
    always_comb begin
        x_pos   = raster_i.h_count - $bits(x_pos)'(video_pkg::H_OFFSCREEN);
        visible = raster_i.h_visible && raster_i.v_visible;
        s0.de   = visible;
        s0.hsync = raster_i.hsync;
        s0.vsync = raster_i.vsync;
        s0.win  = visible && !cfg_i.blank &&
                  (x_pos >= cfg_i.left) && (x_pos < cfg_i.right);
        s0.odd  = x_pos[0] ^ cfg_i.left[0];     // parity of x - left
    end

    assign head     = buf_mem[rd_ptr];
    assign pop      = s1.win && s1.odd && (count != 2'd0);
    assign credit_o = pop;

    always_ff @(posedge clk) begin
        if (word_i.valid) begin
            buf_mem[wr_ptr] <= word_i.data;
        end
    end

    // two word fifo, emptied at line fetch start
    always_ff @(posedge clk) begin
        if (reset_i || raster_i.fetch_start) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count   <= '0;
        end else begin
            if (word_i.valid) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + $bits(count)'(word_i.valid) - $bits(count)'(pop);
        end
    end

    // three stage pipeline, output three clocks after h_count
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1              <= '0;
            s2              <= '0;
            color_index_o   <= '0;
            dv_de_o         <= 1'b0;
            hsync_o         <= 1'b0;
            vsync_o         <= 1'b0;
        end else begin
            s1              <= s0;
            s2.de           <= s1.de;
            s2.hsync        <= s1.hsync;
            s2.vsync        <= s1.vsync;
            s2.win          <= s1.win;
            s2.pix          <= s1.odd ? head[7:0] : head[15:8];     // high byte first
            dv_de_o         <= s2.de;
            hsync_o         <= s2.hsync;
            vsync_o         <= s2.vsync;
            if (!s2.de) begin
                color_index_o <= '0;
            end else if (s2.win) begin
                color_index_o <= s2.pix ^ cfg_i.colorbase;
            end else begin
                color_index_o <= cfg_i.border;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/video_gen.sv
// raster video generator top: timing, registers, line fetch and pixel shifter
`default_nettype none

module video_gen (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    // register access
    input  wire logic                   reg_wr_i,
    input  wire video_pkg::reg_num_t    reg_num_i,
    input  wire video_pkg::reg_word_u   reg_data_i,
    output video_pkg::word_t            reg_data_o,
    output logic                        video_intr_o,
    // vram read port
    output logic                        vram_sel_o,
    output video_pkg::addr_t            vram_addr_o,
    input  wire video_pkg::word_t       vram_data_i,
    // video out
    output video_pkg::color_t           color_index_o,
    output logic                        dv_de_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        h_blank_o,
    output logic                        v_blank_o
);

    video_pkg::raster_t     raster;
    video_pkg::vid_cfg_t    cfg;
    video_pkg::fetch_word_t fetch_word;
    logic                   credit;

    assign h_blank_o = ~raster.h_visible;
    assign v_blank_o = ~raster.v_visible;

    video_timing u_timing (
        .clk            (clk),
        .reset_i        (reset_i),
        .cfg_blank_i    (cfg.blank),
        .raster_o       (raster)
    );

    video_regs u_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_wr_i       (reg_wr_i),
        .reg_num_i      (reg_num_i),
        .reg_data_i     (reg_data_i),
        .raster_i       (raster),
        .reg_data_o     (reg_data_o),
        .video_intr_o   (video_intr_o),
        .cfg_o          (cfg)
    );

    line_fetch u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_i       (raster),
        .cfg_i          (cfg),
        .credit_i       (credit),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_i    (vram_data_i),
        .word_o         (fetch_word)
    );

    pixel_shifter u_shifter (
        .clk            (clk),
        .reset_i        (reset_i),
        .raster_i       (raster),
        .cfg_i          (cfg),
        .word_i         (fetch_word),
        .credit_o       (credit),
        .color_index_o  (color_index_o),
        .dv_de_o        (dv_de_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o)
    );

endmodule

`default_nettype wire

// File: tests/video_gen_assert.sv
// video generator protocol checks: credit-limited reads, hsync width, interrupt and enable
`default_nettype none

module video_gen_assert (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       vram_sel_o,
    input  wire logic       fetch_start,
    input  wire logic       credit,
    input  wire logic       hsync_o,
    input  wire logic       video_intr_o,
    input  wire logic       dv_de_o,
    input  wire logic       h_blank_o,
    input  wire logic       v_blank_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [2:0] vis_d;          // raster visibility, delayed to output stage
    int         hs_len;         // cycles hsync has been high
    logic [2:0] in_use;         // buffer words claimed by reads since line start

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vis_d   <= '0;
            hs_len  <= 0;
            in_use  <= 3'(video_pkg::FETCH_CREDITS);   // no room before first line start
        end else begin
            vis_d   <= {vis_d[1:0], !(h_blank_o || v_blank_o)};
            hs_len  <= hsync_o ? hs_len + 1 : 0;
            if (fetch_start) begin
                in_use <= '0;
            end else begin
                in_use <= in_use + 3'(vram_sel_o) - 3'(credit);
            end
        end
    end

    read_needs_credit: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> (in_use < 3'(video_pkg::FETCH_CREDITS)))
        else $error("vram read issued with no credit");

    hsync_width: assert property (@(posedge clk) disable iff (reset_i)
        $fell(hsync_o) |-> (hs_len == video_pkg::H_SYNC_END - video_pkg::H_SYNC_START))
        else $error("hsync pulse has wrong width");

    intr_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        video_intr_o |=> !video_intr_o)
        else $error("video interrupt longer than one cycle");

    de_in_visible: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_o |-> vis_d[2])
        else $error("display enable high outside visible area");

endmodule

bind video_gen video_gen_assert u_assert (
    .clk            (clk),
    .reset_i        (reset_i),
    .vram_sel_o     (vram_sel_o),
    .fetch_start    (raster.fetch_start),
    .credit         (credit),
    .hsync_o        (hsync_o),
    .video_intr_o   (video_intr_o),
    .dv_de_o        (dv_de_o),
    .h_blank_o      (h_blank_o),
    .v_blank_o      (v_blank_o)
);

`default_nettype wire

// File: tests/video_gen_tb.sv
// video generator testbench: vram model, register table, frame and interrupt checks
`default_nettype none

module video_gen_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LIMIT = 2000;    // clocks allowed for any wait, over three frames

    logic                   clk;
    logic                   reset_i;
    logic                   reg_wr_i;
    video_pkg::reg_num_t    reg_num_i;
    video_pkg::reg_word_u   reg_data_i;
    video_pkg::word_t       reg_data_o;
    logic                   video_intr_o;
    logic                   vram_sel_o;
    video_pkg::addr_t       vram_addr_o;
    video_pkg::word_t       vram_data_i;
    video_pkg::color_t      color_index_o;
    logic                   dv_de_o;
    logic                   hsync_o;
    logic                   vsync_o;
    logic                   h_blank_o;
    logic                   v_blank_o;

    video_pkg::word_t       vram [256];
    video_pkg::word_t       rd_next;
    video_pkg::vid_cfg_t    rows [5];
    video_pkg::vid_cfg_t    defaults;
    video_pkg::word_t       rd;
    int                     n_intr;

    video_gen u_video_gen (.*);

    always #50 clk = ~clk;

    // one cycle read latency, data driven just after the edge
    always begin
        @(negedge clk);
        rd_next = vram_sel_o ? vram[vram_addr_o[7:0]] : 16'hxxxx;
        @(posedge clk);
        #1 vram_data_i = rd_next;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input video_pkg::word_t got, input video_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_color(input video_pkg::color_t got, input video_pkg::color_t exp,
                               input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    // pixel from the window, address and xor rules
    function automatic video_pkg::color_t expected_pixel(input video_pkg::vid_cfg_t c,
                                                         input int x, input int y);
        int                 off;
        video_pkg::addr_t   a;
        video_pkg::word_t   w;
        if (c.blank || x < int'(c.left) || x >= int'(c.right)) begin
            return c.border;
        end
        off = x - int'(c.left);
        a   = c.start_addr + video_pkg::addr_t'(y) * c.line_len + video_pkg::addr_t'(off / 2);
        w   = vram[a[7:0]];
        return ((off % 2) == 0 ? w[15:8] : w[7:0]) ^ c.colorbase;
    endfunction

    task automatic write_reg(input video_pkg::reg_num_t num, input video_pkg::reg_word_u d);
        @(posedge clk);
        #1;
        reg_wr_i    = 1'b1;
        reg_num_i   = num;
        reg_data_i  = d;
        @(posedge clk);
        #1 reg_wr_i = 1'b0;
    endtask

    task automatic read_reg(input video_pkg::reg_num_t num, output video_pkg::word_t v);
        @(posedge clk);
        #1 reg_num_i = num;
        @(posedge clk);
        #1 v = reg_data_o;
    endtask

    task automatic wait_vsync(input logic level);
        int cycles;
        cycles = 0;
        while (vsync_o !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) begin
                stop_on_timeout("vsync");
            end
        end
    endtask

    // one frame of enable-high pixels, starting after vsync
    task automatic capture_frame(input video_pkg::vid_cfg_t c);
        int n;
        int cycles;
        int n_open;         // clocks with neither blank flag set
        int n_vlines;       // clocks on visible lines
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        wait_vsync(1'b0);
        n = 0;
        cycles = 0;
        n_open = 0;
        n_vlines = 0;
        while (n < video_pkg::VISIBLE_WIDTH * video_pkg::VISIBLE_HEIGHT) begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) begin
                stop_on_timeout("visible pixels");
            end
            if (c.blank) begin
                check_bit(vram_sel_o, 1'b0, "vram read while blanked");
            end
            if (!h_blank_o && !v_blank_o) begin
                n_open++;
            end
            if (!v_blank_o) begin
                n_vlines++;
            end
            if (dv_de_o) begin
                check_color(color_index_o,
                            expected_pixel(c, n % video_pkg::VISIBLE_WIDTH,
                                           n / video_pkg::VISIBLE_WIDTH),
                            $sformatf("pixel %0d,%0d", n % 32, n / 32));
                n++;
            end
        end
        // blank flags run ahead of the pixel outputs
        check_word(16'(n_open), 16'(video_pkg::VISIBLE_WIDTH * video_pkg::VISIBLE_HEIGHT),
                   "unblanked clocks per frame");
        check_word(16'(n_vlines), 16'(video_pkg::VISIBLE_HEIGHT * video_pkg::H_TOTAL),
                   "clocks on visible lines");
    endtask

    task automatic apply_row(input video_pkg::vid_cfg_t c);
        video_pkg::reg_word_u d;
        video_pkg::word_t     v;
        d.raw = {8'h00, c.border};
        write_reg(video_pkg::XR_VID_CTRL, d);
        d.raw = 16'(c.left);
        write_reg(video_pkg::XR_VID_LEFT, d);
        d.raw = 16'(c.right);
        write_reg(video_pkg::XR_VID_RIGHT, d);
        d.raw = '0;
        d.gfx.colorbase = c.colorbase;
        d.gfx.blank     = c.blank;
        write_reg(video_pkg::XR_PA_GFX_CTRL, d);
        d.raw = c.start_addr;
        write_reg(video_pkg::XR_PA_DISP_ADDR, d);
        d.raw = c.line_len;
        write_reg(video_pkg::XR_PA_LINE_LEN, d);

        read_reg(video_pkg::XR_VID_CTRL, v);
        check_word(v, {8'h00, c.border}, "border readback");
        read_reg(video_pkg::XR_VID_LEFT, v);
        check_word(v, 16'(c.left), "left readback");
        read_reg(video_pkg::XR_VID_RIGHT, v);
        check_word(v, 16'(c.right), "right readback");
        read_reg(video_pkg::XR_PA_GFX_CTRL, v);
        check_word(v, {c.colorbase, c.blank, 7'h00}, "gfx ctrl readback");
        read_reg(video_pkg::XR_PA_DISP_ADDR, v);
        check_word(v, c.start_addr, "start address readback");
        read_reg(video_pkg::XR_PA_LINE_LEN, v);
        check_word(v, c.line_len, "line length readback");
    endtask

    // interrupt pulses between two vsync rises
    task automatic count_intr(input logic sw_trigger, output int n);
        video_pkg::reg_word_u d;
        logic                 prev;
        int                   cycles;
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        if (sw_trigger) begin
            d.raw = '0;
            write_reg(video_pkg::XR_VID_INTR, d);
        end
        n = 0;
        cycles = 0;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            cycles++;
            if (cycles > LIMIT) begin
                stop_on_timeout("end of frame");
            end
            if (video_intr_o) begin
                n++;
            end
            if (vsync_o && !prev) begin
                break;
            end
            prev = vsync_o;
        end
    endtask

    initial begin
        logic [31:0] seed;
        clk         = 1'b0;
        reset_i     = 1'b1;
        reg_wr_i    = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        vram_data_i = '0;
        seed        = 32'd53;
        for (int i = 0; i < 256; i++) begin
            seed    = xorshift32(seed);
            vram[i] = seed[15:0];
        end

        //           border  left   right   cbase  blank start     len
        rows[0] = '{8'h21, 6'd0,  6'd32, 8'h00, 1'b0, 16'h0000, 16'd16};
        rows[1] = '{8'h3c, 6'd4,  6'd28, 8'h5a, 1'b0, 16'h0010, 16'd12};
        rows[2] = '{8'h77, 6'd3,  6'd30, 8'h0f, 1'b0, 16'h0040, 16'd20};
        rows[3] = '{8'h99, 6'd0,  6'd32, 8'hff, 1'b1, 16'h0020, 16'd16};
        rows[4] = '{8'h44, 6'd10, 6'd11, 8'h81, 1'b0, 16'h00f0, 16'd3};
        defaults = '{8'h08, 6'd0, 6'd32, 8'h00, 1'b1, 16'h0000, 16'd16};

        repeat (8) @(posedge clk);
        #1 reset_i = 1'b0;

        read_reg(video_pkg::XR_VID_CTRL, rd);
        check_word(rd, 16'h0008, "default border");
        read_reg(video_pkg::XR_PA_GFX_CTRL, rd);
        check_word(rd, 16'h0080, "default gfx ctrl");
        capture_frame(defaults);

        read_reg(video_pkg::XR_VID_HSIZE, rd);
        check_word(rd, 16'd32, "hsize");
        read_reg(video_pkg::XR_VID_VSIZE, rd);
        check_word(rd, 16'd8, "vsize");

        foreach (rows[i]) begin
            apply_row(rows[i]);
            capture_frame(rows[i]);
        end

        count_intr(1'b0, n_intr);
        check_word(16'(n_intr), 16'd1, "interrupts per frame");
        count_intr(1'b1, n_intr);
        check_word(16'(n_intr), 16'd2, "interrupts with software trigger");

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/video_regs.sv
verilog/line_fetch.sv
verilog/pixel_shifter.sv
verilog/video_gen.sv
tests/video_gen_assert.sv
tests/video_gen_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the video generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module video_gen_tb \
    -f project.f \
    -o video_gen_sim \
    && ./obj_dir/video_gen_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "all tests passed" sim.log && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
